/* run.sh */
#!/usr/bin/env bash
# Builds the node testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
    echo "verilator not found on PATH"
    exit 1
fi

if ! verilator --binary --timing -Wno-fatal --top-module tb_node_top \
        -f sources.f -o tb_node_top; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_node_top; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

/* source/node_core.sv */
// Evaluation core, fetches the program and applies each truth table to the output register
`timescale 1ns/1ns

module node_core
    import node_pkg::*;
#(
    parameter int INPUTS  = 8,
    parameter int OUTPUTS = 8
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    // From the input block
    input  logic               trigger_i,
    input  logic [INPUTS-1:0]  inputs_i,
    // Number of instructions to run
    input  instr_addr_t        prog_len_i,
    // Memory port through the arbiter
    input  logic               gnt_i,
    input  logic               rvalid_i,
    input  node_instr_t        rdata_i,
    output mem_req_t           req_o,
    output logic               req_valid_o,
    // Result
    output logic               eval_done_o,
    output logic [OUTPUTS-1:0] outputs_o
);

    // ==============================
    // State
    // ==============================

    core_state_t          state_q, state_d;
    instr_addr_t          fetch_q, fetch_d;
    // Reads issued but not yet returned
    logic [ADDR_WIDTH:0]  in_flight_q, in_flight_d;
    logic                 pending_q, pending_d;
    logic                 start;
    logic                 last_fetch;
    logic [INPUTS-1:0]    snapshot_q;
    logic [OUTPUTS-1:0]   out_q;
    logic                 op_a, op_b;

    assign last_fetch  = (fetch_q == prog_len_i - 1'b1);
    assign req_valid_o = (state_q == FETCH);
    assign req_o       = '{addr: fetch_q, wr_en: 1'b0, wdata: '0};
    assign eval_done_o = (state_q == DONE);
    assign outputs_o   = out_q;

    // Outstanding read count
    always_comb begin : p_in_flight
        in_flight_d = in_flight_q;
        if (gnt_i) begin
            in_flight_d = in_flight_d + 1'b1;
        end
        if (rvalid_i) begin
            in_flight_d = in_flight_d - 1'b1;
        end
    end

    // ==============================
    // Sequencer
    // ==============================

    always_comb begin : p_next
        state_d   = state_q;
        fetch_d   = fetch_q;
        pending_d = pending_q;
        start     = 1'b0;
        case (state_q)
            IDLE: start = trigger_i;
            FETCH: begin
                pending_d = pending_q || trigger_i;
                // Address held until granted
                if (gnt_i) begin
                    fetch_d = fetch_q + 1'b1;
                    if (last_fetch) state_d = DRAIN;
                end
            end
            DRAIN: begin
                pending_d = pending_q || trigger_i;
                if (in_flight_d == '0) state_d = DONE;
            end
            default: begin
                // Rerun once for any trigger seen while busy
                if (pending_q || trigger_i) begin
                    start     = 1'b1;
                    pending_d = 1'b0;
                end else begin
                    state_d = IDLE;
                end
            end
        endcase
        // Empty program finishes at once
        if (start) begin
            fetch_d = '0;
            state_d = (prog_len_i == '0) ? DONE : FETCH;
        end
    end

    // Operand select, live outputs give program order
    assign op_a = rdata_i.src_a_is_reg ? out_q[rdata_i.src_a] : snapshot_q[rdata_i.src_a];
    assign op_b = rdata_i.src_b_is_reg ? out_q[rdata_i.src_b] : snapshot_q[rdata_i.src_b];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            fetch_q     <= '0;
            in_flight_q <= '0;
            pending_q   <= 1'b0;
            out_q       <= '0;
        end else begin
            state_q     <= state_d;
            fetch_q     <= fetch_d;
            in_flight_q <= in_flight_d;
            pending_q   <= pending_d;
            // Truth table lookup into the target bit
            if (rvalid_i) begin
                out_q[rdata_i.target] <= rdata_i.truth_table[{op_b, op_a}];
            end
        end
    end

    // Inputs frozen for the whole run
    always_ff @(posedge clk_i) begin
        if (start) begin
            snapshot_q <= inputs_i;
        end
    end

endmodule : node_core

/* source/node_inputs.sv */
// Input state tracking for the node, turns signal updates and host triggers into core triggers
`timescale 1ns/1ns

module node_inputs
    import node_pkg::*;
#(
    parameter int INPUTS = 8
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Host trigger, copies next state into current state
    input  logic              trigger_i,
    // External signal update
    input  io_index_t         sig_index_i,
    input  logic              sig_is_seq_i,
    input  logic              sig_state_i,
    input  logic              sig_valid_i,
    // Output loopback, always sequential
    input  io_index_t         loopback_index_i,
    input  logic              loopback_state_i,
    input  logic              loopback_valid_i,
    // To the core
    output logic              core_trigger_o,
    output logic [INPUTS-1:0] core_inputs_o
);

    // ==============================
    // State
    // ==============================

    logic              first_cycle_q, first_cycle_d;
    logic [INPUTS-1:0] curr_q, curr_d;
    logic [INPUTS-1:0] next_q, next_d;
    logic              trigger_q, trigger_d;

    assign core_trigger_o = trigger_q;
    assign core_inputs_o  = curr_q;

    // ==============================
    // Update merge
    // ==============================

    always_comb begin : p_update
        first_cycle_d = first_cycle_q;
        curr_d        = curr_q;
        next_d        = next_q;
        trigger_d     = 1'b0;

        // Host trigger, any difference re-runs the program
        if (trigger_i) begin
            trigger_d     = (curr_q != next_q) || first_cycle_q;
            curr_d        = next_q;
            first_cycle_d = 1'b0;
        end

        // Signal update always lands in the next state
        if (sig_valid_i) begin
            next_d[sig_index_i] = sig_state_i;
            // Combinational inputs take effect at once
            if (!sig_is_seq_i) begin
                curr_d[sig_index_i] = sig_state_i;
                if (curr_q[sig_index_i] != sig_state_i) begin
                    trigger_d = 1'b1;
                end
            end
        end

        // Loopbacks only touch next state, so no evaluation loop can form
        if (loopback_valid_i) begin
            next_d[loopback_index_i] = loopback_state_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            first_cycle_q <= 1'b1;
            curr_q        <= '0;
            next_q        <= '0;
            trigger_q     <= 1'b0;
        end else begin
            first_cycle_q <= first_cycle_d;
            curr_q        <= curr_d;
            next_q        <= next_d;
            trigger_q     <= trigger_d;
        end
    end

endmodule : node_inputs

/* source/node_instr_loader.sv */
// Host load port, holds one instruction write until the arbiter grants it
`timescale 1ns/1ns

module node_instr_loader
    import node_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    // Host write strobe
    input  logic        load_valid_i,
    input  instr_addr_t load_addr_i,
    input  node_instr_t load_instr_i,
    // Arbiter side
    input  logic        gnt_i,
    output mem_req_t    req_o,
    output logic        req_valid_o,
    output logic        load_busy_o
);

    logic     busy_q;
    mem_req_t req_q;
    logic     accept;

    // New writes only when nothing is held, others are dropped
    assign accept = load_valid_i && !busy_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
        end else if (busy_q && gnt_i) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end
    end

    // Held write request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= '{addr: load_addr_i, wr_en: 1'b1, wdata: load_instr_i};
        end
    end

    assign req_o       = req_q;
    assign req_valid_o = busy_q;
    assign load_busy_o = busy_q;

endmodule : node_instr_loader

/* source/node_instr_ram.sv */
// Single-port instruction memory holding the node program, fed through the memory arbiter
`timescale 1ns/1ns

module node_instr_ram
    import node_pkg::*;
(
    input  logic        clk_i,
    input  mem_req_t    req_i,
    input  logic        en_i,
    output node_instr_t rdata_o
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Program storage
    node_instr_t mem [DEPTH];

    // Write or registered read, one access per cycle
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (req_i.wr_en) begin
                mem[req_i.addr] <= req_i.wdata;
            end else begin
                // Data appears the cycle after the read
                rdata_o <= mem[req_i.addr];
            end
        end
    end

endmodule : node_instr_ram

/* source/node_mem_arbiter.sv */
// Fixed-priority arbiter sharing the instruction memory between the host loader and the core
`timescale 1ns/1ns

module node_mem_arbiter
    import node_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    // Loader side, highest priority
    input  mem_req_t loader_req_i,
    input  logic     loader_req_valid_i,
    // Core side
    input  mem_req_t core_req_i,
    input  logic     core_req_valid_i,
    // Grants, same cycle as the request
    output logic     loader_gnt_o,
    output logic     core_gnt_o,
    // Core read data valid
    output logic     core_rvalid_o,
    // RAM port
    output mem_req_t ram_req_o,
    output logic     ram_en_o
);

    logic rvalid_q;

    // ==============================
    // Grant
    // ==============================

    // Loader always wins
    assign loader_gnt_o = loader_req_valid_i;
    assign core_gnt_o   = core_req_valid_i && !loader_req_valid_i;

    // Winning request goes to the RAM
    assign ram_req_o = loader_req_valid_i ? loader_req_i : core_req_i;
    assign ram_en_o  = loader_req_valid_i || core_req_valid_i;

    // ==============================
    // Read return
    // ==============================

    // Loader only writes, so only core reads return data
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= core_gnt_o && !core_req_i.wr_en;
        end
    end

    assign core_rvalid_o = rvalid_q;

endmodule : node_mem_arbiter

/* source/node_outputs.sv */
// Output change detector, emits one update per changed bit and drives the loopback path
`timescale 1ns/1ns

module node_outputs
    import node_pkg::*;
#(
    parameter int OUTPUTS = 8
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    // From the core
    input  logic               eval_done_i,
    input  logic [OUTPUTS-1:0] outputs_i,
    // Outputs looped back as sequential inputs
    input  logic [OUTPUTS-1:0] loopback_mask_i,
    // Output updates
    output io_index_t          out_index_o,
    output logic               out_state_o,
    output logic               out_valid_o,
    // Loopback updates
    output io_index_t          loopback_index_o,
    output logic               loopback_state_o,
    output logic               loopback_valid_o
);

    // Last emitted values
    logic [OUTPUTS-1:0] held_q, held_d;
    // Bits still to send
    logic [OUTPUTS-1:0] pend_q, pend_d;
    // Latest evaluated values
    logic [OUTPUTS-1:0] val_q;
    io_index_t          pick;
    logic               found;

    // Lowest pending bit first
    always_comb begin : p_pick
        found = 1'b0;
        pick  = '0;
        for (int i = 0; i < OUTPUTS; i++) begin
            if (pend_q[i] && !found) begin
                found = 1'b1;
                pick  = io_index_t'(i);
            end
        end
    end

    assign out_valid_o      = found;
    assign out_index_o      = pick;
    assign out_state_o      = val_q[pick];
    assign loopback_valid_o = found && loopback_mask_i[pick];
    assign loopback_index_o = pick;
    assign loopback_state_o = val_q[pick];

    always_comb begin : p_next
        held_d = held_q;
        pend_d = pend_q;
        if (found) begin
            held_d[pick] = val_q[pick];
            pend_d[pick] = 1'b0;
        end
        // New result replaces the mask, still-pending bits fall out of the compare
        if (eval_done_i) begin
            pend_d = outputs_i ^ held_d;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            held_q <= '0;
            pend_q <= '0;
            val_q  <= '0;
        end else begin
            held_q <= held_d;
            pend_q <= pend_d;
            if (eval_done_i) val_q <= outputs_i;
        end
    end

endmodule : node_outputs

/* source/node_pkg.sv */
// Shared widths, types and state encodings for the logic node, imported by every node block
package node_pkg;

    // ==============================
    // Widths
    // ==============================

    // Bit index width, 8 inputs and 8 outputs
    localparam int IOR_WIDTH  = 3;
    // Instruction address width, 16 program slots
    localparam int ADDR_WIDTH = 4;

    // ==============================
    // Types
    // ==============================

    typedef logic [IOR_WIDTH-1:0]  io_index_t;
    typedef logic [ADDR_WIDTH-1:0] instr_addr_t;
    // Indexed by {b, a}
    typedef logic [3:0]            truth_table_t;

    // One program word, 16 bits wide
    typedef struct packed {
        // Unused, keeps the word at 16 bits
        logic         spare;
        logic         src_a_is_reg;
        io_index_t    src_a;
        logic         src_b_is_reg;
        io_index_t    src_b;
        truth_table_t truth_table;
        io_index_t    target;
    } node_instr_t;

    // Instruction memory request, sent by the loader and the core
    typedef struct packed {
        instr_addr_t addr;
        logic        wr_en;
        node_instr_t wdata;
    } mem_req_t;

    // Evaluation core sequencer
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DRAIN,
        DONE
    } core_state_t;

endpackage : node_pkg

/* source/node_top.sv */
// Top level of one logic node, wires the input, memory, core and output blocks together
`timescale 1ns/1ns

module node_top
    import node_pkg::*;
#(
    parameter int INPUTS  = 8,
    parameter int OUTPUTS = 8
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               trigger_i,
    // External signal update
    input  io_index_t          sig_index_i,
    input  logic               sig_is_seq_i,
    input  logic               sig_state_i,
    input  logic               sig_valid_i,
    // Program load
    input  logic               load_valid_i,
    input  instr_addr_t        load_addr_i,
    input  node_instr_t        load_instr_i,
    input  instr_addr_t        prog_len_i,
    input  logic [OUTPUTS-1:0] loopback_mask_i,
    // Output updates
    output io_index_t          out_index_o,
    output logic               out_state_o,
    output logic               out_valid_o,
    output logic               eval_done_o,
    output logic               load_busy_o
);

    // ==============================
    // Internal wiring
    // ==============================

    logic               core_trigger, eval_done;
    logic [INPUTS-1:0]  core_inputs;
    logic [OUTPUTS-1:0] out_state;
    io_index_t          lb_index;
    logic               lb_state, lb_valid;
    mem_req_t           loader_req, core_req, ram_req;
    logic               loader_req_valid, core_req_valid, ram_en;
    logic               loader_gnt, core_gnt, core_rvalid;
    node_instr_t        ram_rdata;

    assign eval_done_o = eval_done;

    node_inputs #(.INPUTS(INPUTS)) u_inputs (
        .clk_i, .arst_n_i, .trigger_i, .sig_index_i, .sig_is_seq_i, .sig_state_i, .sig_valid_i,
        .loopback_index_i(lb_index), .loopback_state_i(lb_state), .loopback_valid_i(lb_valid),
        .core_trigger_o(core_trigger), .core_inputs_o(core_inputs)
    );

    node_instr_loader u_loader (
        .clk_i, .arst_n_i, .load_valid_i, .load_addr_i, .load_instr_i,
        .gnt_i(loader_gnt), .req_o(loader_req), .req_valid_o(loader_req_valid), .load_busy_o
    );

    node_mem_arbiter u_arbiter (
        .clk_i, .arst_n_i,
        .loader_req_i(loader_req), .loader_req_valid_i(loader_req_valid),
        .core_req_i(core_req), .core_req_valid_i(core_req_valid),
        .loader_gnt_o(loader_gnt), .core_gnt_o(core_gnt), .core_rvalid_o(core_rvalid),
        .ram_req_o(ram_req), .ram_en_o(ram_en)
    );

    node_instr_ram u_ram (.clk_i, .req_i(ram_req), .en_i(ram_en), .rdata_o(ram_rdata));

    node_core #(.INPUTS(INPUTS), .OUTPUTS(OUTPUTS)) u_core (
        .clk_i, .arst_n_i, .trigger_i(core_trigger), .inputs_i(core_inputs), .prog_len_i,
        .gnt_i(core_gnt), .rvalid_i(core_rvalid), .rdata_i(ram_rdata),
        .req_o(core_req), .req_valid_o(core_req_valid),
        .eval_done_o(eval_done), .outputs_o(out_state)
    );

    node_outputs #(.OUTPUTS(OUTPUTS)) u_outputs (
        .clk_i, .arst_n_i, .eval_done_i(eval_done), .outputs_i(out_state), .loopback_mask_i,
        .out_index_o, .out_state_o, .out_valid_o,
        .loopback_index_o(lb_index), .loopback_state_o(lb_state), .loopback_valid_o(lb_valid)
    );

endmodule : node_top

/* sources.f */
source/node_pkg.sv
source/node_inputs.sv
source/node_instr_ram.sv
source/node_mem_arbiter.sv
source/node_instr_loader.sv
source/node_core.sv
source/node_outputs.sv
source/node_top.sv
verif/tb_node_top.sv

/* verif/tb_node_top.sv */
// Directed testbench that drives node_top with fixed and random programs against a reference model
`timescale 1ns/1ns

module tb_node_top
    import node_pkg::*;
();

    localparam int INPUTS  = 8;
    localparam int OUTPUTS = 8;

    logic               clk_i, arst_n_i, trigger_i;
    io_index_t          sig_index_i;
    logic               sig_is_seq_i, sig_state_i, sig_valid_i;
    logic               load_valid_i;
    instr_addr_t        load_addr_i;
    node_instr_t        load_instr_i;
    instr_addr_t        prog_len_i;
    logic [OUTPUTS-1:0] loopback_mask_i;
    io_index_t          out_index_o;
    logic               out_state_o, out_valid_o, eval_done_o, load_busy_o;

    // ==============================
    // Reference model state
    // ==============================

    node_instr_t        prog_mem [16];
    logic [INPUTS-1:0]  ref_curr, ref_next;
    logic [OUTPUTS-1:0] ref_out, ref_held;
    // First trigger flag and predicted core trigger
    logic               ref_first, ref_trig;
    logic [31:0]        rng_state;
    int                 exp_idx[$], exp_state[$], got_idx[$], got_state[$];

    node_top #(.INPUTS(INPUTS), .OUTPUTS(OUTPUTS)) UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Some tests failed");
        $fatal(1, "Stopping on a timeout");
    endtask

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic node_instr_t make_instr(logic a_reg, io_index_t a, logic b_reg,
                                               io_index_t b, truth_table_t tt, io_index_t tgt);
        node_instr_t ins;
        ins              = '0;
        ins.src_a_is_reg = a_reg;
        ins.src_a        = a;
        ins.src_b_is_reg = b_reg;
        ins.src_b        = b;
        ins.truth_table  = tt;
        ins.target       = tgt;
        return ins;
    endfunction

    // ==============================
    // Stimulus
    // ==============================

    task automatic load_instr(instr_addr_t addr, node_instr_t instr);
        int cnt;
        @(posedge clk_i);
        load_valid_i <= 1'b1;
        load_addr_i  <= addr;
        load_instr_i <= instr;
        @(posedge clk_i);
        load_valid_i <= 1'b0;
        prog_mem[addr] = instr;
        // Captured write shows as busy until the arbiter grants it
        @(negedge clk_i);
        check_value("load_busy_o", 1, load_busy_o);
        cnt = 0;
        while (load_busy_o) begin
            @(negedge clk_i);
            cnt++;
            if (cnt > 50) report_timeout("load_busy_o to clear");
        end
    endtask

    task automatic send_signal(io_index_t idx, logic state, logic seq);
        @(posedge clk_i);
        sig_valid_i  <= 1'b1;
        sig_index_i  <= idx;
        sig_state_i  <= state;
        sig_is_seq_i <= seq;
        @(posedge clk_i);
        sig_valid_i <= 1'b0;
        // Next state always takes the update and current state only for combinational ones
        ref_trig      = 1'b0;
        ref_next[idx] = state;
        if (!seq) begin
            ref_trig      = (ref_curr[idx] != state);
            ref_curr[idx] = state;
        end
    endtask

    task automatic pulse_trigger();
        @(posedge clk_i);
        trigger_i <= 1'b1;
        @(posedge clk_i);
        trigger_i <= 1'b0;
        ref_trig  = (ref_curr != ref_next) || ref_first;
        ref_curr  = ref_next;
        ref_first = 1'b0;
    endtask

    // ==============================
    // Response collection
    // ==============================

    task automatic wait_done();
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk_i);
            cnt++;
            if (cnt > 100) report_timeout("eval_done_o");
        end while (!eval_done_o);
    endtask

    // Gathers updates until three idle cycles in a row
    task automatic collect_updates();
        int cnt;
        int idle;
        cnt  = 0;
        idle = 0;
        got_idx.delete();
        got_state.delete();
        while (idle < 3) begin
            @(negedge clk_i);
            cnt++;
            if (cnt > 40) report_timeout("the output updates to end");
            if (out_valid_o) begin
                got_idx.push_back(int'(out_index_o));
                got_state.push_back(int'(out_state_o));
                idle = 0;
            end else begin
                idle++;
            end
        end
    endtask

    // Runs the program in order over a frozen input snapshot and builds the change list
    task automatic evaluate_program();
        logic [INPUTS-1:0] snap;
        node_instr_t       ins;
        logic              a, b;
        snap = ref_curr;
        for (int i = 0; i < int'(prog_len_i); i++) begin
            ins = prog_mem[i];
            a   = ins.src_a_is_reg ? ref_out[ins.src_a] : snap[ins.src_a];
            b   = ins.src_b_is_reg ? ref_out[ins.src_b] : snap[ins.src_b];
            ref_out[ins.target] = ins.truth_table[{b, a}];
        end
        exp_idx.delete();
        exp_state.delete();
        for (int i = 0; i < OUTPUTS; i++) begin
            if (ref_out[i] != ref_held[i]) begin
                exp_idx.push_back(i);
                exp_state.push_back(int'(ref_out[i]));
                // Masked outputs land in the next input state only
                if (loopback_mask_i[i]) ref_next[i] = ref_out[i];
            end
        end
        ref_held = ref_out;
    endtask

    task automatic expect_quiet();
        repeat (20) begin
            @(negedge clk_i);
            check_value("eval_done_o", 0, eval_done_o);
            check_value("out_valid_o", 0, out_valid_o);
        end
    endtask

    task automatic check_run();
        if (ref_trig) begin
            wait_done();
            evaluate_program();
            collect_updates();
            check_value("update count", exp_idx.size(), got_idx.size());
            foreach (got_idx[i]) begin
                check_value("out_index_o", exp_idx[i], got_idx[i]);
                check_value("out_state_o", exp_state[i], got_state[i]);
            end
        end else begin
            expect_quiet();
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        int          len;
        logic [31:0] rnd;
        logic [31:0] load_rnd;
        trigger_i       = 1'b0;
        sig_index_i     = '0;
        sig_is_seq_i    = 1'b0;
        sig_state_i     = 1'b0;
        sig_valid_i     = 1'b0;
        load_valid_i    = 1'b0;
        load_addr_i     = '0;
        load_instr_i    = '0;
        prog_len_i      = '0;
        loopback_mask_i = '0;
        arst_n_i        = 1'b0;
        ref_curr        = '0;
        ref_next        = '0;
        ref_out         = '0;
        ref_held        = '0;
        ref_first       = 1'b1;
        ref_trig        = 1'b0;
        rng_state       = 32'h8323;
        repeat (5) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // First trigger with all inputs zero
        load_instr(4'd0, make_instr(1'b0, 3'd0, 1'b0, 3'd0, 4'b0001, 3'd0));
        load_instr(4'd1, make_instr(1'b0, 3'd2, 1'b0, 3'd3, 4'b0110, 3'd1));
        load_instr(4'd2, make_instr(1'b1, 3'd0, 1'b0, 3'd1, 4'b1000, 3'd2));
        load_instr(4'd3, make_instr(1'b1, 3'd1, 1'b0, 3'd4, 4'b1110, 3'd3));
        load_instr(4'd4, make_instr(1'b0, 3'd5, 1'b0, 3'd6, 4'b0111, 3'd4));
        load_instr(4'd5, make_instr(1'b0, 3'd1, 1'b0, 3'd1, 4'b1000, 3'd5));
        @(posedge clk_i);
        prog_len_i <= 4'd6;
        pulse_trigger();
        check_run();

        // Combinational signal evaluates without a host trigger
        send_signal(3'd2, 1'b1, 1'b0);
        check_run();

        // Sequential signal waits for the host trigger
        send_signal(3'd3, 1'b1, 1'b1);
        check_run();
        pulse_trigger();
        check_run();

        // Output 1 loops back to input 1
        @(posedge clk_i);
        loopback_mask_i <= 8'h02;
        send_signal(3'd2, 1'b0, 1'b0);
        check_run();
        expect_quiet();
        pulse_trigger();
        check_run();

        // Loads to unused slots steal memory cycles from a running core
        send_signal(3'd0, 1'b1, 1'b0);
        fork
            begin
                for (int k = 12; k < 16; k++) begin
                    load_rnd = next_rand();
                    load_instr(instr_addr_t'(k), node_instr_t'(load_rnd[15:0]));
                end
            end
            check_run();
        join

        // Random programs and signal sequences
        for (int r = 0; r < 10; r++) begin
            rnd = next_rand();
            len = 1 + int'(rnd % 12);
            for (int i = 0; i < len; i++) begin
                rnd = next_rand();
                load_instr(instr_addr_t'(i), node_instr_t'(rnd[15:0]));
            end
            rnd = next_rand();
            @(posedge clk_i);
            prog_len_i      <= instr_addr_t'(len);
            loopback_mask_i <= rnd[7:0];
            repeat (4) begin
                rnd = next_rand();
                if (rnd[8]) begin
                    send_signal(rnd[2:0], rnd[3], rnd[4]);
                end else begin
                    pulse_trigger();
                end
                check_run();
            end
            pulse_trigger();
            check_run();
        end

        $display("All tests passed");
        $finish;
    end

endmodule : tb_node_top
